/* project.f */
source/revo_pkg.sv
source/reset_sequencer.sv
source/revo_word_generator.sv
source/word_fifo.sv
source/word_serializer.sv
source/revo_trigger_top.sv
test/revo_trigger_properties.sv
test/revo_trigger_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and pass only when the testbench reports a pass
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module revo_trigger_tb -f project.f \
	-o revo_trigger_sim &&
./obj_dir/revo_trigger_sim +verilator+error+limit+1000 | tee /dev/stderr |
	grep -x "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* source/reset_sequencer.sv */
module reset_sequencer (
	input  logic clock50,
	input  logic rst_n,
	output logic serializer_enable,
	output logic generator_enable,
	output logic heartbeat
);
	import revo_pkg::*;

	logic [seq_count_width-1:0] counter;

	// free-running, restarts from zero on every rst_n
	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			counter <= '0;
		end else begin
			counter <= counter + 1'b1;
		end
	end

	// each enable latches high once its count is reached
	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			serializer_enable <= 1'b0;
		end else if (counter == seq_count_width'(serdes_release_cycles - 1)) begin
			serializer_enable <= 1'b1;
		end
	end

	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			generator_enable <= 1'b0;
		end else if (counter == seq_count_width'(generator_release_cycles - 1)) begin
			generator_enable <= 1'b1;
		end
	end

	// slow blink so the board shows it is alive
	assign heartbeat = counter[heartbeat_bit];

endmodule

/* source/revo_pkg.sv */
package revo_pkg;

	// serial word format
	localparam int word_width = 8;
	typedef logic [word_width-1:0] word_t;

	// one revolution is revolution_words * word_width bits
	localparam int revolution_words = 10;
	// marker bit inside slot 0, counted from the msb
	localparam int revo_bit_pos = 5;

	localparam int fifo_depth = 4;

	// release points, counted from the end of rst_n
	localparam int serdes_release_cycles = 32;
	localparam int generator_release_cycles = 128;
	localparam int heartbeat_bit = 4;

	// derived counter widths
	localparam int slot_width = $clog2(revolution_words);
	localparam int fifo_ptr_width = $clog2(fifo_depth);
	localparam int fifo_count_width = $clog2(fifo_depth) + 1;
	localparam int bit_count_width = $clog2(word_width);
	localparam int seq_count_width = $clog2(generator_release_cycles) + 1;

	typedef enum logic {gen_hold, gen_run} gen_state_t;
	typedef enum logic {ser_idle, ser_shift} ser_state_t;

endpackage

/* source/revo_trigger_top.sv */
module revo_trigger_top (
	input  logic clock50,
	input  logic rst_n,
	output logic trigger_lane,
	output logic clock_lane,
	output logic lane_active,
	output logic revo_led,
	output logic led_heartbeat,
	output logic led_ser_reset,
	output logic led_gen_reset
);
	import revo_pkg::*;

	logic serializer_enable;
	logic generator_enable;
	logic push;
	logic pop;
	logic full;
	logic empty;
	word_t push_word;
	word_t pop_word;

	reset_sequencer reset_sequencer_i (
		.clock50           (clock50),
		.rst_n             (rst_n),
		.serializer_enable (serializer_enable),
		.generator_enable  (generator_enable),
		.heartbeat         (led_heartbeat)
	);

	revo_word_generator revo_word_generator_i (
		.clock50          (clock50),
		.rst_n            (rst_n),
		.generator_enable (generator_enable),
		.full             (full),
		.push             (push),
		.push_word        (push_word),
		.revo             (revo_led)
	);

	word_fifo word_fifo_i (
		.clock50   (clock50),
		.rst_n     (rst_n),
		.push      (push),
		.push_word (push_word),
		.pop       (pop),
		.pop_word  (pop_word),
		.full      (full),
		.empty     (empty)
	);

	word_serializer word_serializer_i (
		.clock50           (clock50),
		.rst_n             (rst_n),
		.serializer_enable (serializer_enable),
		.empty             (empty),
		.pop               (pop),
		.pop_word          (pop_word),
		.trigger_lane      (trigger_lane),
		.clock_lane        (clock_lane),
		.lane_active       (lane_active)
	);

	// leds are lit while a stage is still held in reset
	assign led_ser_reset = ~serializer_enable;
	assign led_gen_reset = ~generator_enable;

endmodule

/* source/revo_word_generator.sv */
module revo_word_generator (
	input  logic            clock50,
	input  logic            rst_n,
	input  logic            generator_enable,
	input  logic            full,
	output logic            push,
	output revo_pkg::word_t push_word,
	output logic            revo
);
	import revo_pkg::*;

	gen_state_t state;
	logic [slot_width-1:0] slot;
	word_t marker_word;
	logic slot_zero;

	// single marker bit, position counted from the msb
	assign marker_word = word_t'(1) << (word_width - 1 - revo_bit_pos);

	assign slot_zero = (slot == '0);

	// one word per cycle unless the fifo is full
	assign push = (state == gen_run) && !full;
	assign push_word = slot_zero ? marker_word : '0;
	assign revo = push && slot_zero;

	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= gen_hold;
		end else begin
			case (state)
				gen_hold: begin
					if (generator_enable) begin
						state <= gen_run;
					end
				end
				gen_run: begin
					state <= gen_run;
				end
				default: begin
					state <= gen_hold;
				end
			endcase
		end
	end

	// slot only moves on an actual push, so back-pressure never skips one
	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
		end else if (push) begin
			if (slot == slot_width'(revolution_words - 1)) begin
				slot <= '0;
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

endmodule

/* source/word_fifo.sv */
module word_fifo (
	input  logic            clock50,
	input  logic            rst_n,
	input  logic            push,
	input  revo_pkg::word_t push_word,
	input  logic            pop,
	output revo_pkg::word_t pop_word,
	output logic            full,
	output logic            empty
);
	import revo_pkg::*;

	word_t mem [fifo_depth];
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;
	logic [fifo_count_width-1:0] count;
	logic do_push;
	logic do_pop;

	// ignore strobes that would overflow or underflow
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == fifo_count_width'(fifo_depth));
	assign empty = (count == '0);

	// show-ahead, head word is always on the output
	assign pop_word = mem[rd_ptr];

	always_ff @(posedge clock50) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// occupancy, push and pop together leave it unchanged
	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* source/word_serializer.sv */
module word_serializer (
	input  logic            clock50,
	input  logic            rst_n,
	input  logic            serializer_enable,
	input  logic            empty,
	output logic            pop,
	input  revo_pkg::word_t pop_word,
	output logic            trigger_lane,
	output logic            clock_lane,
	output logic            lane_active
);
	import revo_pkg::*;

	ser_state_t state;
	word_t shift_reg;
	logic [bit_count_width-1:0] bit_cnt;
	logic last_bit;

	assign last_bit = (bit_cnt == bit_count_width'(word_width - 1));

	// start from idle once enabled, or reload on the last bit of a word
	always_comb begin
		pop = 1'b0;
		if (!empty) begin
			if (state == ser_idle) begin
				pop = serializer_enable;
			end else begin
				pop = last_bit;
			end
		end
	end

	assign lane_active = (state == ser_shift);
	assign trigger_lane = lane_active && shift_reg[word_width-1];
	// words have an even bit count, so this keeps alternating across words
	assign clock_lane = lane_active && !bit_cnt[0];

	always_ff @(posedge clock50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= ser_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				ser_idle: begin
					if (pop) begin
						state <= ser_shift;
						bit_cnt <= '0;
					end
				end
				ser_shift: begin
					if (last_bit) begin
						bit_cnt <= '0;
						// underrun drops back to idle
						if (!pop) begin
							state <= ser_idle;
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					state <= ser_idle;
					bit_cnt <= '0;
				end
			endcase
		end
	end

	// msb first
	always_ff @(posedge clock50) begin
		if (pop) begin
			shift_reg <= pop_word;
		end else begin
			shift_reg <= {shift_reg[word_width-2:0], 1'b0};
		end
	end

endmodule

/* test/revo_trigger_properties.sv */
module revo_trigger_properties (
	input logic clock50,
	input logic rst_n,
	input logic empty,
	input logic pop,
	input logic clock_lane,
	input logic lane_active
);
	int assertion_failures = 0;

	// the fifo head is only taken when it holds a word
	no_pop_when_empty: assert property (@(posedge clock50) disable iff (!rst_n)
		!(pop && empty))
	else begin
		assertion_failures++;
		$error("pop raised while the fifo is empty");
	end

	// low while idle, 1 on the first active bit, then toggling across words
	clock_lane_pattern: assert property (@(posedge clock50) disable iff (!rst_n)
		clock_lane == (lane_active && !($past(lane_active) && $past(clock_lane))))
	else begin
		assertion_failures++;
		$error("clock_lane high while lane_active is low or not alternating");
	end

	// no underrun once the lane is running
	lane_stays_active: assert property (@(posedge clock50) disable iff (!rst_n)
		lane_active |=> lane_active)
	else begin
		assertion_failures++;
		$error("lane_active fell without a reset");
	end

endmodule

bind word_serializer revo_trigger_properties revo_trigger_properties_i (
	.clock50     (clock50),
	.rst_n       (rst_n),
	.empty       (empty),
	.pop         (pop),
	.clock_lane  (clock_lane),
	.lane_active (lane_active)
);

/* test/revo_trigger_tb.sv */
module revo_trigger_tb;
	import revo_pkg::*;

	localparam int clock_period = 100;
	localparam int reset_cycles = 16;
	localparam int revolution_bits = revolution_words * word_width;
	localparam int stream_revolutions = 8;
	localparam int start_wait_cycles = 4 * word_width;
	// four release periods plus eight revolutions, doubled
	localparam int timeout_cycles = (4 * generator_release_cycles + 8 * revolution_bits) * 2;

	logic clock50;
	logic rst_n;
	logic trigger_lane;
	logic clock_lane;
	logic lane_active;
	logic revo_led;
	logic led_heartbeat;
	logic led_ser_reset;
	logic led_gen_reset;

	int bit_errors;
	int count_errors;
	int other_errors;
	int total_errors;
	int cycle_count;
	int seed;

	revo_trigger_top revo_trigger_top_i (
		.clock50       (clock50),
		.rst_n         (rst_n),
		.trigger_lane  (trigger_lane),
		.clock_lane    (clock_lane),
		.lane_active   (lane_active),
		.revo_led      (revo_led),
		.led_heartbeat (led_heartbeat),
		.led_ser_reset (led_ser_reset),
		.led_gen_reset (led_gen_reset)
	);

	initial begin
		clock50 = 1'b0;
		forever begin
			#(clock_period / 2) clock50 = ~clock50;
		end
	end

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			bit_errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			count_errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic check_reset_outputs;
		check_bit("trigger_lane", trigger_lane, 1'b0);
		check_bit("clock_lane", clock_lane, 1'b0);
		check_bit("lane_active", lane_active, 1'b0);
		check_bit("revo_led", revo_led, 1'b0);
		check_bit("led_heartbeat", led_heartbeat, 1'b0);
		check_bit("led_ser_reset", led_ser_reset, 1'b1);
		check_bit("led_gen_reset", led_gen_reset, 1'b1);
	endtask

	// reset acts at once, before the next rising edge
	task automatic apply_reset;
		@(negedge clock50);
		rst_n = 1'b0;
		#1;
		check_reset_outputs();
		repeat (reset_cycles) begin
			@(negedge clock50);
			check_reset_outputs();
		end
		rst_n = 1'b1;
	endtask

	// cycles are counted in rising edges since rst_n went high
	task automatic check_release;
		int cycle;
		int ser_fall;
		int gen_fall;
		int wait_cycles;
		ser_fall = 0;
		gen_fall = 0;
		for (cycle = 1; cycle <= generator_release_cycles; cycle++) begin
			@(negedge clock50);
			if (!led_ser_reset && ser_fall == 0) begin
				ser_fall = cycle;
			end
			if (!led_gen_reset && gen_fall == 0) begin
				gen_fall = cycle;
			end
			check_bit("lane_active", lane_active, 1'b0);
			// heartbeat follows the cycle count since release
			check_bit("led_heartbeat", led_heartbeat, cycle[heartbeat_bit]);
		end
		check_count("led_ser_reset fall cycle", ser_fall, serdes_release_cycles);
		check_count("led_gen_reset fall cycle", gen_fall, generator_release_cycles);
		wait_cycles = 0;
		while (!lane_active && wait_cycles < start_wait_cycles) begin
			@(negedge clock50);
			wait_cycles++;
		end
		if (!lane_active) begin
			other_errors++;
			$display("lane_active did not rise within %0d cycles of the generator release",
				start_wait_cycles);
		end
	endtask

	// bit 0 is the first cycle with lane_active high
	task automatic check_stream(input int num_bits);
		int count;
		int markers;
		markers = 0;
		for (count = 0; count < num_bits; count++) begin
			check_bit("lane_active", lane_active, 1'b1);
			check_bit("trigger_lane", trigger_lane, (count % revolution_bits) == revo_bit_pos);
			check_bit("clock_lane", clock_lane, (count % 2) == 0);
			if (trigger_lane) begin
				markers++;
			end
			@(negedge clock50);
		end
		check_count("marker count", markers,
			(num_bits + revolution_bits - 1 - revo_bit_pos) / revolution_bits);
	endtask

	task automatic test_power_up;
		apply_reset();
		check_release();
		check_stream(stream_revolutions * revolution_bits);
	endtask

	task automatic test_mid_run_reset;
		int offset;
		// somewhere inside the second revolution, clear of its marker
		offset = revo_bit_pos + 8 + ($unsigned($random(seed)) % (revolution_bits - 16));
		check_stream(revolution_bits + offset);
		apply_reset();
		check_release();
		check_stream(stream_revolutions * revolution_bits);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clock50);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		bit_errors = 0;
		count_errors = 0;
		other_errors = 0;
		seed = 32'h8426;
		test_power_up();
		test_mid_run_reset();
		total_errors = bit_errors + count_errors + other_errors +
			revo_trigger_top_i.word_serializer_i.revo_trigger_properties_i.assertion_failures;
		$display("errors: %0d bit, %0d count, %0d other, %0d assertion, %0d total",
			bit_errors, count_errors, other_errors,
			revo_trigger_top_i.word_serializer_i.revo_trigger_properties_i.assertion_failures,
			total_errors);
		if (total_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
